// File: hw/joiner_macros.svh
`ifndef JOINER_MACROS_SVH
`define JOINER_MACROS_SVH

// Number of input streams joined into one output packet
`define JOINER_CHANNELS 4

// Beat width of every stream in bits
`define JOINER_DATA_WIDTH 16

// One byte enable per data byte
`define JOINER_KEEP_WIDTH (`JOINER_DATA_WIDTH / 8)

// Bits needed to encode a channel number
`define JOINER_CHAN_BITS 2

`endif

// File: hw/joiner_stream_pkg.sv
`include "joiner_macros.svh"

package joiner_stream_pkg;

  // One beat of stream data
  typedef logic [`JOINER_DATA_WIDTH-1:0] word_t;

  // Byte enables of one beat
  typedef logic [`JOINER_KEEP_WIDTH-1:0] keep_t;

  // One bit per input channel, used for masks, requests and grants
  typedef logic [`JOINER_CHANNELS-1:0] chan_mask_t;

  // Encoded channel number
  typedef logic [`JOINER_CHAN_BITS-1:0] chan_idx_t;

endpackage

// File: hw/joiner_ctrl_pkg.sv
package joiner_ctrl_pkg;

  // Operation FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DONE  = 2'd2,
    ERROR = 2'd3
  } op_state_e;

  // Status flags kept together in the controller
  typedef logic [2:0] status_t;

  // Bit positions inside status_t
  localparam int unsigned STAT_BUSY     = 0;
  localparam int unsigned STAT_COMPLETE = 1;
  localparam int unsigned STAT_ERROR    = 2;

endpackage

// File: hw/joiner_ctrl.sv
`timescale 1ns/100ps

`include "joiner_macros.svh"

module joiner_ctrl (
  input  logic                          clk,
  input  logic                          int_rst,
  input  logic                          operation_start,
  input  logic                          lock,
  input  logic                          interrupt,
  input  joiner_stream_pkg::chan_mask_t use_channels,
  input  joiner_stream_pkg::chan_mask_t acknowledge,
  input  logic                          out_last_fire,
  output joiner_stream_pkg::chan_mask_t pending,
  output logic                          enable,
  output logic                          arb_clear,
  output logic                          operation_busy,
  output logic                          operation_complete,
  output logic                          operation_error
);

  joiner_ctrl_pkg::op_state_e    state_q;
  joiner_ctrl_pkg::op_state_e    state_d;
  joiner_ctrl_pkg::status_t      status_q;
  joiner_stream_pkg::chan_mask_t pending_q;
  logic                          busy;
  logic                          start_ok;

  assign busy = (state_q == joiner_ctrl_pkg::RUN);

  // A start is only taken when nothing is locking the controller
  assign start_ok = operation_start && !lock;

  // Streams may move while running, or whenever the lock is released
  assign enable = busy || !lock;

  // Arbiter restarts from channel 0 for every operation
  assign arb_clear = interrupt || !busy;

  always_comb begin
    state_d = state_q;
    case (state_q)
      joiner_ctrl_pkg::IDLE,
      joiner_ctrl_pkg::DONE: begin
        if (start_ok) begin
          if (use_channels != '0) begin
            state_d = joiner_ctrl_pkg::RUN;
          end else begin
            state_d = joiner_ctrl_pkg::ERROR;
          end
        end else begin
          state_d = joiner_ctrl_pkg::IDLE;
        end
      end
      joiner_ctrl_pkg::RUN: begin
        // A running join finishes even under lock
        if (out_last_fire) begin
          state_d = joiner_ctrl_pkg::DONE;
        end
      end
      joiner_ctrl_pkg::ERROR: begin
        state_d = joiner_ctrl_pkg::IDLE;
      end
      default: begin
        state_d = joiner_ctrl_pkg::IDLE;
      end
    endcase
    // Abort wins over everything else
    if (interrupt) begin
      state_d = joiner_ctrl_pkg::IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (int_rst) begin
      state_q   <= joiner_ctrl_pkg::IDLE;
      status_q  <= '0;
      pending_q <= '0;
    end else begin
      state_q <= state_d;
      status_q[joiner_ctrl_pkg::STAT_BUSY]     <= (state_d == joiner_ctrl_pkg::RUN);
      status_q[joiner_ctrl_pkg::STAT_COMPLETE] <= (state_d == joiner_ctrl_pkg::DONE);
      status_q[joiner_ctrl_pkg::STAT_ERROR]    <= (state_d == joiner_ctrl_pkg::ERROR);
      if (state_d != joiner_ctrl_pkg::RUN) begin
        pending_q <= '0;
      end else if (!busy) begin
        // Entering RUN, load the requested channels
        pending_q <= use_channels;
      end else begin
        // Drop each channel once its packet has gone out
        pending_q <= pending_q & ~acknowledge;
      end
    end
  end

  assign pending            = pending_q;
  assign operation_busy     = status_q[joiner_ctrl_pkg::STAT_BUSY];
  assign operation_complete = status_q[joiner_ctrl_pkg::STAT_COMPLETE];
  assign operation_error    = status_q[joiner_ctrl_pkg::STAT_ERROR];

endmodule

// File: hw/rr_arbiter.sv
`timescale 1ns/100ps

`include "joiner_macros.svh"

module rr_arbiter (
  input  logic                          clk,
  input  logic                          int_rst,
  input  logic                          arb_clear,
  input  joiner_stream_pkg::chan_mask_t request,
  input  joiner_stream_pkg::chan_mask_t acknowledge,
  output joiner_stream_pkg::chan_mask_t grant,
  output logic                          grant_valid,
  output joiner_stream_pkg::chan_idx_t  grant_idx
);

  joiner_stream_pkg::chan_mask_t grant_q;
  joiner_stream_pkg::chan_mask_t mask_q;
  joiner_stream_pkg::chan_mask_t mask_d;
  joiner_stream_pkg::chan_mask_t req_eff;
  joiner_stream_pkg::chan_idx_t  idx_q;
  joiner_stream_pkg::chan_idx_t  pick_idx;
  logic                          valid_q;
  logic                          pick_found;
  logic                          hold;

  // Blocked until the granted channel acknowledges
  assign hold = valid_q && ((acknowledge & grant_q) == '0);

  // The channel being acknowledged is no longer a candidate
  assign req_eff = request & ~(acknowledge & grant_q);

  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    // Channels above the last grant first, lowest wins
    for (int i = `JOINER_CHANNELS - 1; i >= 0; i--) begin
      if (req_eff[i] && mask_q[i]) begin
        pick_found = 1'b1;
        pick_idx   = joiner_stream_pkg::chan_idx_t'(i);
      end
    end
    // Wrap around to the bottom
    if (!pick_found) begin
      for (int i = `JOINER_CHANNELS - 1; i >= 0; i--) begin
        if (req_eff[i]) begin
          pick_found = 1'b1;
          pick_idx   = joiner_stream_pkg::chan_idx_t'(i);
        end
      end
    end
    for (int j = 0; j < `JOINER_CHANNELS; j++) begin
      mask_d[j] = (j > int'(pick_idx));
    end
  end

  always_ff @(posedge clk) begin
    if (int_rst || arb_clear) begin
      grant_q <= '0;
      valid_q <= 1'b0;
      idx_q   <= '0;
      mask_q  <= '1;
    end else if (!hold) begin
      valid_q <= pick_found;
      if (pick_found) begin
        grant_q <= joiner_stream_pkg::chan_mask_t'(1) << pick_idx;
        idx_q   <= pick_idx;
        mask_q  <= mask_d;
      end else begin
        grant_q <= '0;
      end
    end
  end

  assign grant       = grant_q;
  assign grant_valid = valid_q;
  assign grant_idx   = idx_q;

endmodule

// File: hw/stream_mux.sv
`timescale 1ns/100ps

`include "joiner_macros.svh"

module stream_mux (
  input  logic                                           clk,
  input  logic                                           int_rst,
  input  logic [`JOINER_CHANNELS*`JOINER_DATA_WIDTH-1:0] s_tdata,
  input  logic [`JOINER_CHANNELS*`JOINER_KEEP_WIDTH-1:0] s_tkeep,
  input  joiner_stream_pkg::chan_mask_t                  s_tvalid,
  input  joiner_stream_pkg::chan_mask_t                  s_tlast,
  input  joiner_stream_pkg::chan_idx_t                   grant_idx,
  input  logic                                           grant_valid,
  input  logic                                           enable,
  input  joiner_stream_pkg::chan_mask_t                  pending,
  input  logic                                           m_tready,
  output joiner_stream_pkg::chan_mask_t                  s_tready,
  output joiner_stream_pkg::word_t                       m_tdata,
  output joiner_stream_pkg::keep_t                       m_tkeep,
  output logic                                           m_tvalid,
  output logic                                           m_tlast,
  output joiner_stream_pkg::chan_mask_t                  acknowledge,
  output logic                                           out_last_fire,
  output logic                                           transmission
);

  joiner_stream_pkg::chan_mask_t sel_onehot;
  logic                          sel_ok;
  logic                          only_left;
  logic                          fire;
  logic                          sel_last;

  assign sel_onehot = joiner_stream_pkg::chan_mask_t'(1) << grant_idx;

  // Granted channel may talk only while enabled and still owed a packet
  assign sel_ok = grant_valid && enable && pending[grant_idx];

  assign m_tdata  = s_tdata[grant_idx*`JOINER_DATA_WIDTH +: `JOINER_DATA_WIDTH];
  assign m_tkeep  = s_tkeep[grant_idx*`JOINER_KEEP_WIDTH +: `JOINER_KEEP_WIDTH];
  assign m_tvalid = sel_ok && s_tvalid[grant_idx];
  assign sel_last = s_tlast[grant_idx];

  // Last selected channel closes the joined packet
  assign only_left = (pending & ~sel_onehot) == '0;
  assign m_tlast   = sel_last && only_left;

  // Back-pressure reaches the granted channel only
  assign s_tready = (sel_ok && m_tready) ? sel_onehot : '0;

  assign fire          = m_tvalid && m_tready;
  assign acknowledge   = (fire && sel_last) ? sel_onehot : '0;
  assign out_last_fire = fire && m_tlast;

  // Flags a beat accepted in the previous cycle
  always_ff @(posedge clk) begin
    if (int_rst) begin
      transmission <= 1'b0;
    end else begin
      transmission <= fire;
    end
  end

endmodule

// File: hw/packet_joiner.sv
`timescale 1ns/100ps

`include "joiner_macros.svh"

module packet_joiner (
  input  logic                                           clk,
  input  logic                                           int_rst,
  input  logic                                           operation_start,
  input  joiner_stream_pkg::chan_mask_t                  use_channels,
  input  logic                                           lock,
  input  logic                                           interrupt,
  output logic                                           operation_busy,
  output logic                                           operation_complete,
  output logic                                           operation_error,
  output logic                                           transmission,
  input  logic [`JOINER_CHANNELS*`JOINER_DATA_WIDTH-1:0] s_tdata,
  input  logic [`JOINER_CHANNELS*`JOINER_KEEP_WIDTH-1:0] s_tkeep,
  input  joiner_stream_pkg::chan_mask_t                  s_tvalid,
  output joiner_stream_pkg::chan_mask_t                  s_tready,
  input  joiner_stream_pkg::chan_mask_t                  s_tlast,
  output joiner_stream_pkg::word_t                       m_tdata,
  output joiner_stream_pkg::keep_t                       m_tkeep,
  output logic                                           m_tvalid,
  input  logic                                           m_tready,
  output logic                                           m_tlast
);

  joiner_stream_pkg::chan_mask_t pending;
  joiner_stream_pkg::chan_mask_t acknowledge;
  joiner_stream_pkg::chan_idx_t  grant_idx;
  logic                          enable;
  logic                          arb_clear;
  logic                          grant_valid;
  logic                          out_last_fire;

  joiner_ctrl u_ctrl (
    .clk                (clk),
    .int_rst            (int_rst),
    .operation_start    (operation_start),
    .lock               (lock),
    .interrupt          (interrupt),
    .use_channels       (use_channels),
    .acknowledge        (acknowledge),
    .out_last_fire      (out_last_fire),
    .pending            (pending),
    .enable             (enable),
    .arb_clear          (arb_clear),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error)
  );

  // Mux works from the encoded index, so the one-hot grant stays open
  rr_arbiter u_arb (
    .clk         (clk),
    .int_rst     (int_rst),
    .arb_clear   (arb_clear),
    .request     (pending),
    .acknowledge (acknowledge),
    .grant       (),
    .grant_valid (grant_valid),
    .grant_idx   (grant_idx)
  );

  stream_mux u_mux (
    .clk           (clk),
    .int_rst       (int_rst),
    .s_tdata       (s_tdata),
    .s_tkeep       (s_tkeep),
    .s_tvalid      (s_tvalid),
    .s_tlast       (s_tlast),
    .grant_idx     (grant_idx),
    .grant_valid   (grant_valid),
    .enable        (enable),
    .pending       (pending),
    .m_tready      (m_tready),
    .s_tready      (s_tready),
    .m_tdata       (m_tdata),
    .m_tkeep       (m_tkeep),
    .m_tvalid      (m_tvalid),
    .m_tlast       (m_tlast),
    .acknowledge   (acknowledge),
    .out_last_fire (out_last_fire),
    .transmission  (transmission)
  );

endmodule

// File: tests/joiner_checker.sv
`timescale 1ns/100ps

`include "joiner_macros.svh"

module joiner_checker (
  input  logic                                           clk,
  input  logic                                           int_rst,
  input  logic                                           operation_start,
  input  joiner_stream_pkg::chan_mask_t                  use_channels,
  input  logic                                           lock,
  input  logic                                           interrupt,
  input  logic                                           operation_busy,
  input  logic                                           operation_complete,
  input  logic                                           operation_error,
  input  logic                                           transmission,
  input  logic [`JOINER_CHANNELS*`JOINER_DATA_WIDTH-1:0] s_tdata,
  input  logic [`JOINER_CHANNELS*`JOINER_KEEP_WIDTH-1:0] s_tkeep,
  input  joiner_stream_pkg::chan_mask_t                  s_tvalid,
  input  joiner_stream_pkg::chan_mask_t                  s_tready,
  input  joiner_stream_pkg::chan_mask_t                  s_tlast,
  input  joiner_stream_pkg::word_t                       m_tdata,
  input  joiner_stream_pkg::keep_t                       m_tkeep,
  input  logic                                           m_tvalid,
  input  logic                                           m_tready,
  input  logic                                           m_tlast,
  output int                                             value_errors,
  output int                                             other_errors
);

  localparam int DW = `JOINER_DATA_WIDTH;
  localparam int KW = `JOINER_KEEP_WIDTH;
  localparam int ST_IDLE = 0;
  localparam int ST_RUN  = 1;
  localparam int ST_DONE = 2;
  localparam int ST_ERR  = 3;

  // Accepted input beat as {last, keep, data}
  logic [DW+KW:0]                in_beats[$];
  int                            st;
  joiner_stream_pkg::chan_mask_t rem;
  logic                          prev_fire;

  initial begin
    value_errors = 0;
    other_errors = 0;
    st           = ST_IDLE;
    rem          = '0;
    prev_fire    = 1'b0;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_problem(input string what);
    other_errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  function automatic int lowest_channel(input joiner_stream_pkg::chan_mask_t m);
    int idx;
    idx = -1;
    for (int i = `JOINER_CHANNELS - 1; i >= 0; i--) begin
      if (m[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Everything has settled half a cycle after the edge
  always @(negedge clk) begin
    joiner_stream_pkg::chan_mask_t in_fire;
    joiner_stream_pkg::chan_mask_t exp_sel;
    logic [DW+KW:0]                beat;
    logic                          out_fire;
    logic                          exp_last;
    logic                          join_done;
    int                            exp_ch;
    if (int_rst) begin
      st        = ST_IDLE;
      rem       = '0;
      prev_fire = 1'b0;
      in_beats.delete();
    end else begin
      out_fire  = m_tvalid && m_tready;
      in_fire   = s_tvalid & s_tready;
      join_done = 1'b0;
      compare_value("operation_busy", 32'(st == ST_RUN), 32'(operation_busy));
      compare_value("operation_complete", 32'(st == ST_DONE), 32'(operation_complete));
      compare_value("operation_error", 32'(st == ST_ERR), 32'(operation_error));
      compare_value("transmission", 32'(prev_fire), 32'(transmission));

      // Only the lowest channel still owed may be ready
      exp_ch  = (st == ST_RUN) ? lowest_channel(rem) : -1;
      exp_sel = (exp_ch >= 0) ? joiner_stream_pkg::chan_mask_t'(1) << exp_ch : '0;
      if ((s_tready & ~exp_sel) != '0) begin
        report_problem("s_tready high on a channel that is not next in the join");
      end

      for (int c = 0; c < `JOINER_CHANNELS; c++) begin
        if (in_fire[c]) begin
          in_beats.push_back({s_tlast[c], s_tkeep[c*KW +: KW], s_tdata[c*DW +: DW]});
        end
      end

      if (out_fire) begin
        if (exp_ch < 0) begin
          report_problem("output beat accepted while no join was running");
        end else if (in_beats.size() == 0) begin
          report_problem("output beat accepted without an input beat");
        end else begin
          beat     = in_beats.pop_front();
          exp_last = beat[DW+KW] && ((rem & ~exp_sel) == '0);
          compare_value("m_tdata", 32'(beat[DW-1:0]), 32'(m_tdata));
          compare_value("m_tkeep", 32'(beat[DW +: KW]), 32'(m_tkeep));
          compare_value("m_tlast", 32'(exp_last), 32'(m_tlast));
          if (beat[DW+KW]) begin
            rem       = rem & ~exp_sel;
            join_done = (rem == '0);
          end
        end
      end
      if (in_beats.size() != 0) begin
        report_problem("input beat accepted without a matching output beat");
        in_beats.delete();
      end
      prev_fire = out_fire;

      // Expected controller state for the next cycle
      if (interrupt) begin
        st  = ST_IDLE;
        rem = '0;
      end else if (st == ST_IDLE || st == ST_DONE) begin
        st = ST_IDLE;
        if (operation_start && !lock) begin
          if (use_channels == '0) begin
            st = ST_ERR;
          end else begin
            st  = ST_RUN;
            rem = use_channels;
          end
        end
      end else if (st == ST_RUN) begin
        if (join_done) begin
          st = ST_DONE;
        end
      end else begin
        st = ST_IDLE;
      end
    end
  end

endmodule

// File: tests/tb_packet_joiner.sv
`timescale 1ns/100ps

`include "joiner_macros.svh"

module tb_packet_joiner;

  localparam int CH      = `JOINER_CHANNELS;
  localparam int DW      = `JOINER_DATA_WIDTH;
  localparam int KW      = `JOINER_KEEP_WIDTH;
  localparam int NUM_OPS = 40;
  // Up to 4 beats per channel per operation, 8 cycles of slack per beat
  localparam int TIMEOUT_CYCLES = NUM_OPS * CH * 4 * 8 + 200;

  logic                          clk;
  logic                          int_rst;
  logic                          operation_start;
  joiner_stream_pkg::chan_mask_t use_channels;
  logic                          lock;
  logic                          interrupt;
  logic                          operation_busy;
  logic                          operation_complete;
  logic                          operation_error;
  logic                          transmission;
  logic [CH*DW-1:0]              s_tdata;
  logic [CH*KW-1:0]              s_tkeep;
  joiner_stream_pkg::chan_mask_t s_tvalid;
  joiner_stream_pkg::chan_mask_t s_tready;
  joiner_stream_pkg::chan_mask_t s_tlast;
  joiner_stream_pkg::word_t      m_tdata;
  joiner_stream_pkg::keep_t      m_tkeep;
  logic                          m_tvalid;
  logic                          m_tready;
  logic                          m_tlast;

  logic [31:0]                   lfsr;
  int                            left [CH];
  joiner_stream_pkg::chan_mask_t src_fire;
  int                            cycles;
  int                            timeouts;
  int                            value_errors;
  int                            other_errors;

  packet_joiner uut (
    .clk(clk), .int_rst(int_rst),
    .operation_start(operation_start), .use_channels(use_channels),
    .lock(lock), .interrupt(interrupt),
    .operation_busy(operation_busy), .operation_complete(operation_complete),
    .operation_error(operation_error), .transmission(transmission),
    .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid),
    .s_tready(s_tready), .s_tlast(s_tlast),
    .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid),
    .m_tready(m_tready), .m_tlast(m_tlast)
  );

  joiner_checker u_chk (
    .clk(clk), .int_rst(int_rst),
    .operation_start(operation_start), .use_channels(use_channels),
    .lock(lock), .interrupt(interrupt),
    .operation_busy(operation_busy), .operation_complete(operation_complete),
    .operation_error(operation_error), .transmission(transmission),
    .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid),
    .s_tready(s_tready), .s_tlast(s_tlast),
    .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid),
    .m_tready(m_tready), .m_tlast(m_tlast),
    .value_errors(value_errors), .other_errors(other_errors)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Source handshakes, taken where they are stable
  always @(negedge clk) begin
    src_fire = s_tvalid & s_tready;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] draw(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic update_streams();
    for (int c = 0; c < CH; c++) begin
      if (src_fire[c]) begin
        s_tvalid[c] = 1'b0;
        left[c]--;
        if (left[c] == 0) begin
          left[c] = int'(draw(2)) + 1;
        end
      end
      // Roughly three idle cycles in four offer a new beat
      if (!s_tvalid[c] && draw(2) != 0) begin
        s_tvalid[c]         = 1'b1;
        s_tdata[c*DW +: DW] = draw(DW);
        s_tkeep[c*KW +: KW] = draw(KW);
        s_tlast[c]          = (left[c] == 1);
      end
    end
    m_tready = (draw(2) != 0);
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
    update_streams();
  endtask

  task automatic run_op(input joiner_stream_pkg::chan_mask_t mask);
    tick();
    operation_start = 1'b1;
    use_channels    = mask;
    tick();
    operation_start = 1'b0;
    while (!operation_complete && !operation_error) begin
      tick();
    end
    tick();
  endtask

  // Abort once the first beat has gone out
  task automatic abort_op(input joiner_stream_pkg::chan_mask_t mask);
    tick();
    operation_start = 1'b1;
    use_channels    = mask;
    tick();
    operation_start = 1'b0;
    while (!transmission && !operation_complete) begin
      tick();
    end
    interrupt = 1'b1;
    tick();
    interrupt = 1'b0;
    tick();
  endtask

  task automatic report_counts();
    $display("Errors: value %0d, other %0d, timeout %0d",
             value_errors, other_errors, timeouts);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      timeouts++;
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr            = 32'hac76;
    cycles          = 0;
    timeouts        = 0;
    src_fire        = '0;
    int_rst         = 1'b1;
    operation_start = 1'b0;
    use_channels    = '0;
    lock            = 1'b0;
    interrupt       = 1'b0;
    s_tdata         = '0;
    s_tkeep         = '0;
    s_tvalid        = '0;
    s_tlast         = '0;
    m_tready        = 1'b0;
    for (int c = 0; c < CH; c++) begin
      left[c] = int'(draw(2)) + 1;
    end
    repeat (4) tick();
    int_rst = 1'b0;

    // Empty mask gives only the error pulse
    run_op('0);

    // Start under lock must be ignored
    lock = 1'b1;
    tick();
    operation_start = 1'b1;
    use_channels    = 4'b0110;
    tick();
    operation_start = 1'b0;
    repeat (6) tick();
    lock = 1'b0;
    run_op(4'b0110);

    abort_op(4'b1111);
    run_op(4'b1111);

    for (int n = 4; n < NUM_OPS; n++) begin
      run_op(joiner_stream_pkg::chan_mask_t'(draw(CH)));
    end
    repeat (4) tick();

    report_counts();
    if (value_errors + other_errors + timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
hw/joiner_stream_pkg.sv
hw/joiner_ctrl_pkg.sv
hw/joiner_ctrl.sv
hw/rr_arbiter.sv
hw/stream_mux.sv
hw/packet_joiner.sv
tests/joiner_checker.sv
tests/tb_packet_joiner.sv

// File: Bender.yml
package:
  name: packet_joiner

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/joiner_stream_pkg.sv
      - hw/joiner_ctrl_pkg.sv
      - hw/joiner_ctrl.sv
      - hw/rr_arbiter.sv
      - hw/stream_mux.sv
      - hw/packet_joiner.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/joiner_checker.sv
      - tests/tb_packet_joiner.sv
